/* bench/tb_transport_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_transport_glue
    import sata_tl_pkg::*;
();

    localparam int TMO = 2000;  // cycles allowed per wait

    logic clk, rst;
    dword_t h2d_data, d2h_data, ll_tx_data, ll_rx_data;
    dmask_t h2d_mask, d2h_mask, ll_tx_mask, ll_rx_mask;
    fis_type_t h2d_type, d2h_type;
    logic h2d_valid, h2d_ready, d2h_valid, d2h_ready, d2h_many;
    logic ll_tx_last, ll_tx_valid, ll_tx_strobe, frame_req, frame_ack;
    logic ll_rx_valid, incom_start, incom_done, incom_invalidate, ll_rx_busy;
    logic link_established, frame_done_bad, st_cleared, serr_dh;
    logic [1:0] phy_speed;

    int errors, checks, tests;
    int seed = 27936;        // payloads and lengths
    int link_seed = 27936;   // background strobes, ready and ack
    bit strobe_en, drain_en, auto_ack, ack_req, fill_chk;
    int rx_stored;           // d2h entries written while fill flags are watched
    int rise_depth;          // h2d entries queued when frame_req was first seen
    int rises;               // frame_req rises since the last head write
    logic req_seen;
    fifo_word_t h2d_q[$];    // words accepted from the host, in order
    fifo_word_t rx_q[$];     // expected d2h entries

    sata_transport_glue #(.FIFO_ADDR_WIDTH(7), .BITS_TO_START_XMIT(6)) sata_transport_glue_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic expect_eq(input string name, input logic [35:0] got, input logic [35:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout waiting for %s at %0t", what, $time);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s done, errors so far %0d", tests, name, errors);
    endtask

    // holds the word until h2d_ready is seen, returns 1 ns after the accepting edge
    task automatic send_word(input fis_type_t t, input dmask_t m, input dword_t d);
        int n;
        h2d_type = t;
        h2d_mask = m;
        h2d_data = d;
        h2d_valid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!h2d_ready && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (n >= TMO) give_up("h2d_ready");
        @(posedge clk);
        #1;
        h2d_valid = 1'b0;
    endtask

    task automatic send_fis(input int len);  // head, data..., last
        for (int i = 0; i < len; i++) begin
            send_word((i == 0) ? H2D_HEAD : ((i == len - 1) ? H2D_LAST : H2D_DATA),
                      dmask_t'($random(seed)), dword_t'($random(seed)));
        end
    endtask

    task automatic receive_words(input int len);
        dword_t d;
        dmask_t m;
        incom_start = 1'b1;
        idle_cycles(1);
        incom_start = 1'b0;
        for (int i = 0; i < len; i++) begin
            d = dword_t'($random(seed));
            m = dmask_t'($random(seed));
            ll_rx_data = d;
            ll_rx_mask = m;
            ll_rx_valid = 1'b1;
            rx_q.push_back({((i == 0) ? D2H_HEAD : D2H_DATA), m, d});  // head first
            idle_cycles(1);
        end
        ll_rx_valid = 1'b0;
    endtask

    task automatic end_fis(input bit bad, input bit status_due);
        if (bad) incom_invalidate = 1'b1;
        else incom_done = 1'b1;
        if (status_due) rx_q.push_back({(bad ? D2H_ERR : D2H_OK), 34'h0});
        idle_cycles(1);
        incom_invalidate = 1'b0;
        incom_done = 1'b0;
        idle_cycles(4);  // err entry lands two edges late
    endtask

    task automatic wait_tx_drained;
        int n;
        n = 0;
        while ((ll_tx_valid || h2d_q.size() != 0) && n < TMO) begin
            idle_cycles(1);
            n++;
        end
        if (n >= TMO) give_up("h2d fifo to drain");
    endtask

    task automatic wait_rx_drained;
        int n;
        n = 0;
        while ((d2h_valid || rx_q.size() != 0) && n < TMO) begin
            idle_cycles(1);
            n++;
        end
        if (n >= TMO) give_up("d2h fifo to drain");
    endtask

    task automatic wait_req(input logic level);
        int n;
        n = 0;
        while (frame_req !== level && n < TMO) begin
            idle_cycles(1);
            n++;
        end
        if (n >= TMO) give_up("frame_req level");
    endtask

    // link and host stand-ins, all driven 1 ns after the edge
    always @(posedge clk) begin
        #1;
        ll_tx_strobe = strobe_en && (($random(link_seed) & 1) != 0);
        d2h_ready = drain_en && (($random(link_seed) & 3) != 0);
        if (frame_ack) begin
            frame_ack = 1'b0;  // single cycle
        end else if (frame_req && (auto_ack ? (($random(link_seed) & 3) == 0) : ack_req)) begin
            frame_ack = 1'b1;
            ack_req = 1'b0;
        end
    end

    // scoreboard, sampled mid-cycle where everything has settled
    always @(negedge clk) begin
        fifo_word_t w;
        if (rst) begin
            h2d_q.delete();
            rx_q.delete();
            req_seen = 1'b0;
        end else begin
            expect_eq("ll_tx_valid", ll_tx_valid, h2d_q.size() != 0);
            expect_eq("h2d_ready", h2d_ready, h2d_q.size() < 120);  // depth 128 minus 8
            if (ll_tx_strobe && ll_tx_valid && h2d_q.size() != 0) begin
                w = h2d_q.pop_front();
                expect_eq("ll_tx_data", ll_tx_data, w[31:0]);
                expect_eq("ll_tx_mask", ll_tx_mask, w[33:32]);
                expect_eq("ll_tx_last", ll_tx_last, w[35:34] == H2D_LAST);
            end
            if (d2h_valid && d2h_ready) begin
                if (rx_q.size() == 0) begin
                    errors++;
                    $display("d2h entry delivered to the host when none was expected at %0t",
                             $time);
                end else begin
                    w = rx_q.pop_front();
                    expect_eq("d2h_type", d2h_type, w[35:34]);
                    // status payload is don't care
                    if (w[35:34] == D2H_HEAD || w[35:34] == D2H_DATA) begin
                        expect_eq("d2h_data", d2h_data, w[31:0]);
                        expect_eq("d2h_mask", d2h_mask, w[33:32]);
                    end
                end
            end
            if (frame_req && !req_seen) begin
                rise_depth = h2d_q.size();
                expect_eq("frame_req rises for one head", rises, 0);
                rises++;
            end
            req_seen = frame_req;
            if (fill_chk) begin  // no pops here, so stored count equals fill
                expect_eq("d2h_many", d2h_many, rx_stored >= 8);
                expect_eq("ll_rx_busy", ll_rx_busy, rx_stored >= 64);
                if (ll_rx_valid) rx_stored++;
            end
            if (st_cleared) begin
                h2d_q.delete();
                rx_q.delete();
            end else if (h2d_valid && h2d_ready) begin
                h2d_q.push_back({h2d_type, h2d_mask, h2d_data});
                if (h2d_type == H2D_HEAD) rises = 0;
            end
        end
    end

    a_speed: assert property (@(posedge clk) phy_speed == (link_established ? 2'd2 : 2'd0))
        else begin
            errors++;
            $display("MISMATCH phy_speed got %h expected %h", phy_speed,
                     link_established ? 2'd2 : 2'd0);
        end
    a_serr: assert property (@(posedge clk) serr_dh == (link_established && frame_done_bad))
        else begin
            errors++;
            $display("MISMATCH serr_dh got %h expected %h", serr_dh,
                     link_established && frame_done_bad);
        end
    a_req_fall: assert property (@(posedge clk) disable iff (rst) frame_ack |=> !frame_req)
        else begin
            errors++;
            $display("frame_req still high one cycle after frame_ack at %0t", $time);
        end
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        frame_req && !frame_ack && !st_cleared |=> frame_req)
        else begin
            errors++;
            $display("frame_req dropped without frame_ack at %0t", $time);
        end

    initial begin
        rst = 1'b1;
        {h2d_data, h2d_mask, h2d_type, h2d_valid, d2h_ready} = '0;
        {ll_tx_strobe, frame_ack, ll_rx_data, ll_rx_mask, ll_rx_valid} = '0;
        {incom_start, incom_done, incom_invalidate} = '0;
        {link_established, frame_done_bad, st_cleared} = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(2);

        strobe_en = 1'b1;  // random bursts against random pops
        auto_ack = 1'b1;
        for (int f = 0; f < 8; f++) send_fis(2 + ($random(seed) & 15));
        wait_tx_drained();
        strobe_en = 1'b0;
        wait_req(1'b0);
        auto_ack = 1'b0;
        report_test("transmit ordering");

        idle_cycles(2);
        send_fis(5);
        expect_eq("frame_req after last", frame_req, 1'b1);
        idle_cycles(3);
        expect_eq("frame_req rise depth", rise_depth, 5);
        ack_req = 1'b1;
        wait_req(1'b0);
        idle_cycles(8);
        expect_eq("frame_req after ack", frame_req, 1'b0);  // one request per head
        strobe_en = 1'b1;
        wait_tx_drained();
        strobe_en = 1'b0;
        idle_cycles(2);
        for (int i = 0; i < 79; i++) begin
            send_word((i == 0) ? H2D_HEAD : H2D_DATA, 2'b11, dword_t'(i));
        end
        expect_eq("frame_req before last", frame_req, 1'b1);
        expect_eq("frame_req rise depth", rise_depth, 65);  // edge after fill hit 64
        send_word(H2D_LAST, 2'b11, 32'h4f);
        ack_req = 1'b1;
        wait_req(1'b0);
        strobe_en = 1'b1;
        wait_tx_drained();
        strobe_en = 1'b0;
        report_test("frame request");

        drain_en = 1'b1;
        for (int f = 0; f < 4; f++) begin
            receive_words(1 + ($random(seed) & 7));
            end_fis(f[0], 1'b1);
            end_fis(f[0], 1'b0);  // repeated end strobe, no entry
        end
        wait_rx_drained();
        idle_cycles(4);
        expect_eq("d2h_valid", d2h_valid, 1'b0);
        report_test("receive tagging");

        drain_en = 1'b0;
        idle_cycles(2);
        rx_stored = 0;
        fill_chk = 1'b1;
        receive_words(70);
        idle_cycles(1);
        fill_chk = 1'b0;
        end_fis(1'b0, 1'b1);
        drain_en = 1'b1;
        wait_rx_drained();
        auto_ack = 1'b1;
        for (int i = 0; i < 120; i++) begin
            send_word((i == 0) ? H2D_HEAD : H2D_DATA, 2'b11, dword_t'(i));
        end
        expect_eq("h2d_ready at 120", h2d_ready, 1'b0);
        h2d_type = H2D_LAST;  // offered while not ready, must not enter
        h2d_valid = 1'b1;
        idle_cycles(5);
        h2d_valid = 1'b0;
        strobe_en = 1'b1;
        wait_tx_drained();
        strobe_en = 1'b0;
        wait_req(1'b0);
        auto_ack = 1'b0;
        report_test("fill flags");

        drain_en = 1'b0;
        idle_cycles(2);
        for (int i = 0; i < 120; i++) begin  // h2d full enough to drop ready
            send_word((i == 0) ? H2D_HEAD : H2D_DATA, 2'b11, dword_t'(i));
        end
        receive_words(10);  // enough for d2h_many
        idle_cycles(2);
        expect_eq("frame_req before flush", frame_req, 1'b1);
        expect_eq("h2d_ready before flush", h2d_ready, 1'b0);
        expect_eq("d2h_many before flush", d2h_many, 1'b1);
        st_cleared = 1'b1;
        idle_cycles(1);
        st_cleared = 1'b0;
        expect_eq("d2h_valid", d2h_valid, 1'b0);
        expect_eq("ll_tx_valid", ll_tx_valid, 1'b0);
        expect_eq("h2d_ready", h2d_ready, 1'b1);
        expect_eq("frame_req", frame_req, 1'b0);
        expect_eq("d2h_many", d2h_many, 1'b0);
        drain_en = 1'b1;
        receive_words(2);  // receive path still usable
        end_fis(1'b0, 1'b1);
        wait_rx_drained();
        report_test("flush");

        for (int i = 0; i < 40; i++) begin
            link_established = 1'($random(seed));
            frame_done_bad = 1'($random(seed));
            idle_cycles(1);
        end
        link_established = 1'b0;
        frame_done_bad = 1'b0;
        idle_cycles(2);
        report_test("status outputs");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/d2h_fis_tagger.sv */
`timescale 1ns/1ps
`default_nettype none

module d2h_fis_tagger
    import sata_tl_pkg::*;
#(
    parameter int FIFO_ADDR_WIDTH = 9   // d2h fifo depth is 2**FIFO_ADDR_WIDTH
) (
    input  logic                     clk,
    input  logic                     rst,              // also pulsed by software stop
    input  logic                     ll_rx_valid,      // one received dword
    input  logic                     incom_start,      // strobe, new incoming fis
    input  logic                     incom_done,       // strobe, clean end
    input  logic                     incom_invalidate, // strobe, bad end
    input  logic [FIFO_ADDR_WIDTH:0] fill,             // d2h fifo fill
    output logic                     d2h_wr,           // push into d2h fifo
    output fis_type_t                d2h_tag,          // type of the pushed word
    output logic                     ll_rx_busy,       // ask link to throttle
    output logic                     d2h_many          // several dwords ready
);

    localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

    localparam logic [FIFO_ADDR_WIDTH:0] BUSY_LEVEL =
        (FIFO_ADDR_WIDTH+1)'(DEPTH - D2H_BUSY_MARGIN);
    localparam logic [FIFO_ADDR_WIDTH:0] MANY_LEVEL =
        (FIFO_ADDR_WIDTH+1)'(D2H_MANY_LEVEL);

    logic invalidate_r;  // lets the last dword of a bad fis through first
    logic fis_end;       // end of fis seen, ok or err
    logic status_push;   // one extra entry carrying the end status

    assign fis_end = incom_done || invalidate_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            invalidate_r <= 1'b0;
        end else begin
            invalidate_r <= incom_invalidate;
        end
    end

    // tag for the next word: head first, data after, status at the end
    always_ff @(posedge clk) begin
        if (rst || incom_start) begin
            d2h_tag <= D2H_HEAD;
        end else if (ll_rx_valid) begin
            d2h_tag <= D2H_DATA;
        end else if (fis_end) begin
            d2h_tag <= invalidate_r ? D2H_ERR : D2H_OK;
        end
    end

    // only after data, so a repeated end strobe pushes nothing
    always_ff @(posedge clk) begin
        if (rst) begin
            status_push <= 1'b0;
        end else begin
            status_push <= fis_end && (d2h_tag == D2H_DATA);
        end
    end

    // status entry carries whatever is on the rx bus, host ignores it
    assign d2h_wr = ll_rx_valid || status_push;

    // fill flags, combinational from the registered fill
    assign ll_rx_busy = fill >= BUSY_LEVEL;
    assign d2h_many   = fill >= MANY_LEVEL;

    // a start strobe tags the following word, never one on the same cycle
    a_start_not_data: assert property (
        @(posedge clk) disable iff (rst)
        !(incom_start && ll_rx_valid)
    ) else $error("d2h_fis_tagger: incom_start with ll_rx_valid");

endmodule

`default_nettype wire

/* hdl/fis_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module fis_fifo
    import sata_tl_pkg::*;
#(
    parameter int FIFO_ADDR_WIDTH = 9   // depth is 2**FIFO_ADDR_WIDTH
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,   // software stop, drops all entries
    input  logic                     wr,
    input  fifo_word_t               wdata,
    input  logic                     rd,      // pop head, ignored when empty
    output fifo_word_t               rdata,   // head entry, shown ahead
    output logic                     nempty,
    output logic [FIFO_ADDR_WIDTH:0] fill     // entries currently stored
);

    localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

    fifo_word_t                 mem [DEPTH];  // storage
    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;       // next slot to write
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;       // current head slot
    logic                       full;
    logic                       wr_en;        // qualified write
    logic                       rd_en;        // qualified read

    assign full   = fill[FIFO_ADDR_WIDTH];    // msb only set at exactly DEPTH
    assign nempty = |fill;

    // a write into a full fifo is lost, a read from an empty one does nothing
    assign wr_en = wr && !full;
    assign rd_en = rd && nempty;

    // payload store
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // show-ahead head, visible the cycle after its write
    assign rdata = mem[rd_ptr];

    // pointers, wrap naturally at DEPTH
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // fill tracks the pointer distance, one extra bit to tell full from empty
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            fill <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   fill <= fill + 1'b1;  // push only
                2'b01:   fill <= fill - 1'b1;  // pop only
                default: fill <= fill;         // both or neither
            endcase
        end
    end

    // writer must watch its own fill flag, h2d_ready on the host side
    // and ll_rx_busy on the link side
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst || flush)
        wr |-> !full
    ) else $error("fis_fifo: write while full, entry dropped");

    // counter must stay in range over any push/pop sequence
    a_fill_bound: assert property (
        @(posedge clk) disable iff (rst)
        fill <= (FIFO_ADDR_WIDTH+1)'(DEPTH)
    ) else $error("fis_fifo: fill %0d above depth", fill);

endmodule

`default_nettype wire

/* hdl/h2d_xmit_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module h2d_xmit_ctrl
    import sata_tl_pkg::*;
#(
    parameter int FIFO_ADDR_WIDTH    = 9,  // h2d fifo depth is 2**FIFO_ADDR_WIDTH
    parameter int BITS_TO_START_XMIT = 6   // early start once 2**this entries queued
) (
    input  logic                     clk,
    input  logic                     rst,        // also pulsed by software stop
    input  fis_type_t                h2d_type,   // type of the offered host word
    input  logic                     h2d_valid,
    input  logic [FIFO_ADDR_WIDTH:0] fill,       // h2d fifo fill
    input  logic                     frame_ack,  // link took the request
    output logic                     h2d_wr,     // push into h2d fifo
    output logic                     h2d_ready,
    output logic                     frame_req   // level, held until frame_ack
);

    localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

    // ready drops while there is still slack for a few words in flight
    localparam logic [FIFO_ADDR_WIDTH:0] READY_LIMIT =
        (FIFO_ADDR_WIDTH+1)'(DEPTH - H2D_READY_MARGIN);

    logic head_pending;  // head queued, request not yet raised
    logic head_wr;       // head dword accepted this cycle
    logic last_wr;       // last dword accepted this cycle
    logic early_start;   // enough queued to start before last arrives
    logic start_xmit;

    assign h2d_ready = fill < READY_LIMIT;          // straight from fill
    assign h2d_wr    = h2d_valid && h2d_ready;      // valid/ready handshake

    assign head_wr = h2d_wr && (h2d_type == H2D_HEAD);
    assign last_wr = h2d_wr && (h2d_type == H2D_LAST);

    // any bit at or above the threshold means fill >= 2**BITS_TO_START_XMIT
    assign early_start = |fill[FIFO_ADDR_WIDTH:BITS_TO_START_XMIT];

    assign start_xmit = head_pending && (last_wr || early_start);

    // one request per head; a raised request consumes the pending flag
    always_ff @(posedge clk) begin
        if (rst || frame_req) begin
            head_pending <= 1'b0;
        end else if (head_wr) begin
            head_pending <= 1'b1;
        end
    end

    // Ack wins over a new start: the pending flag is already gone by the
    // time the link answers, so nothing is lost by dropping the request.
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_req <= 1'b0;
        end else if (frame_ack) begin
            frame_req <= 1'b0;          // falls the edge after ack
        end else if (start_xmit) begin
            frame_req <= 1'b1;          // rises the edge after the trigger
        end
    end

    // link side handshake, spans the request lifetime
    a_ack_in_req: assert property (
        @(posedge clk) disable iff (rst)
        frame_ack |-> frame_req
    ) else $error("h2d_xmit_ctrl: frame_ack without frame_req");

endmodule

`default_nettype wire

/* hdl/sata_tl_pkg.sv */
`default_nettype none

package sata_tl_pkg;

    // payload widths shared by both directions
    typedef logic [31:0] dword_t;     // one sata dword
    typedef logic [1:0]  dmask_t;     // halfword enables, normally 2'b11
    typedef logic [1:0]  fis_type_t;  // type tag, codes differ per direction

    // one fifo entry: {type, mask, dword}
    typedef logic [$bits(fis_type_t)+$bits(dmask_t)+$bits(dword_t)-1:0] fifo_word_t;

    // host -> device type codes
    localparam fis_type_t H2D_DATA = 2'd0;  // fis body dword
    localparam fis_type_t H2D_HEAD = 2'd1;  // first dword of a fis
    localparam fis_type_t H2D_LAST = 2'd2;  // final dword of a fis

    // device -> host type codes
    localparam fis_type_t D2H_DATA = 2'd0;  // fis body dword
    localparam fis_type_t D2H_HEAD = 2'd1;  // first dword of a fis
    localparam fis_type_t D2H_OK   = 2'd2;  // status entry, clean end
    localparam fis_type_t D2H_ERR  = 2'd3;  // status entry, invalidated fis

    // reported speed once the link is up
    localparam logic [1:0] PHY_SPEED_GEN2 = 2'd2;

    // Fill margins. The h2d and busy margins count down from the FIFO depth,
    // the many level counts up from empty.
    localparam int H2D_READY_MARGIN = 8;   // room left when h2d_ready drops
    localparam int D2H_MANY_LEVEL   = 8;   // entries needed for d2h_many
    localparam int D2H_BUSY_MARGIN  = 64;  // room left when link is throttled

endpackage

`default_nettype wire

/* hdl/sata_transport_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module sata_transport_glue
    import sata_tl_pkg::*;
#(
    parameter int FIFO_ADDR_WIDTH    = 9,  // both fifos, depth 2**FIFO_ADDR_WIDTH
    parameter int BITS_TO_START_XMIT = 6   // must stay below FIFO_ADDR_WIDTH
) (
    input  logic       clk,
    input  logic       rst,

    // host dma, host -> device
    input  dword_t     h2d_data,
    input  dmask_t     h2d_mask,
    input  fis_type_t  h2d_type,          // data / head / last
    input  logic       h2d_valid,
    output logic       h2d_ready,

    // host dma, device -> host
    output dword_t     d2h_data,
    output dmask_t     d2h_mask,
    output fis_type_t  d2h_type,          // data / head / ok / err
    output logic       d2h_valid,
    output logic       d2h_many,
    input  logic       d2h_ready,

    // link, transmit side
    output dword_t     ll_tx_data,
    output dmask_t     ll_tx_mask,
    output logic       ll_tx_last,
    output logic       ll_tx_valid,
    input  logic       ll_tx_strobe,      // pop one word
    output logic       frame_req,
    input  logic       frame_ack,

    // link, receive side
    input  dword_t     ll_rx_data,
    input  dmask_t     ll_rx_mask,
    input  logic       ll_rx_valid,
    input  logic       incom_start,
    input  logic       incom_done,
    input  logic       incom_invalidate,
    output logic       ll_rx_busy,

    // status and control
    input  logic       link_established,
    input  logic       frame_done_bad,    // device rejected our fis
    input  logic       st_cleared,        // PxCMD.ST cleared by software
    output logic [1:0] phy_speed,
    output logic       serr_dh            // handshake error
);

    logic                     ctl_rst;    // control logic restarts with the flush
    logic                     h2d_wr;
    logic                     d2h_wr;
    logic                     d2h_rd;
    fis_type_t                d2h_tag;
    fis_type_t                tx_type;    // type of the h2d head entry
    fifo_word_t               h2d_rdata;
    fifo_word_t               d2h_rdata;
    logic [FIFO_ADDR_WIDTH:0] h2d_fill;
    logic [FIFO_ADDR_WIDTH:0] d2h_fill;

    assign ctl_rst = rst || st_cleared;
    assign d2h_rd  = d2h_valid && d2h_ready;

    assign {tx_type, ll_tx_mask, ll_tx_data} = h2d_rdata;
    assign {d2h_type, d2h_mask, d2h_data}    = d2h_rdata;
    assign ll_tx_last = (tx_type == H2D_LAST);  // link needs end of frame

    assign phy_speed = link_established ? PHY_SPEED_GEN2 : 2'd0;
    assign serr_dh   = link_established && frame_done_bad;

    fis_fifo #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) h2d_fifo_i (
        .clk    (clk),
        .rst    (rst),
        .flush  (st_cleared),
        .wr     (h2d_wr),
        .wdata  ({h2d_type, h2d_mask, h2d_data}),
        .rd     (ll_tx_strobe),             // strobe on empty is dropped inside
        .rdata  (h2d_rdata),
        .nempty (ll_tx_valid),
        .fill   (h2d_fill)
    );

    h2d_xmit_ctrl #(
        .FIFO_ADDR_WIDTH    (FIFO_ADDR_WIDTH),
        .BITS_TO_START_XMIT (BITS_TO_START_XMIT)
    ) h2d_xmit_ctrl_i (
        .clk       (clk),
        .rst       (ctl_rst),
        .h2d_type  (h2d_type),
        .h2d_valid (h2d_valid),
        .fill      (h2d_fill),
        .frame_ack (frame_ack),
        .h2d_wr    (h2d_wr),
        .h2d_ready (h2d_ready),
        .frame_req (frame_req)
    );

    fis_fifo #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) d2h_fifo_i (
        .clk    (clk),
        .rst    (rst),
        .flush  (st_cleared),
        .wr     (d2h_wr),
        .wdata  ({d2h_tag, ll_rx_mask, ll_rx_data}),
        .rd     (d2h_rd),
        .rdata  (d2h_rdata),
        .nempty (d2h_valid),
        .fill   (d2h_fill)
    );

    d2h_fis_tagger #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) d2h_fis_tagger_i (
        .clk              (clk),
        .rst              (ctl_rst),
        .ll_rx_valid      (ll_rx_valid),
        .incom_start      (incom_start),
        .incom_done       (incom_done),
        .incom_invalidate (incom_invalidate),
        .fill             (d2h_fill),
        .d2h_wr           (d2h_wr),
        .d2h_tag          (d2h_tag),
        .ll_rx_busy       (ll_rx_busy),
        .d2h_many         (d2h_many)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_transport_glue -f sim.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* sim.f */
hdl/sata_tl_pkg.sv
hdl/fis_fifo.sv
hdl/h2d_xmit_ctrl.sv
hdl/d2h_fis_tagger.sv
hdl/sata_transport_glue.sv
bench/tb_transport_glue.sv
